/* design/hw_mgr_cfg.svh */
`ifndef HW_MGR_CFG_SVH
`define HW_MGR_CFG_SVH

// Boot phase delays, all in clock cycles
// Force release until the shutdown reset pulse
`define HW_SD_FORCE_DELAY 20
// Shutdown reset pulse width
`define HW_SD_RST_PULSE 5
// Settle time after the pulse, before DMA start
`define HW_SD_RST_DELAY 30

// Timeouts for the handshaking boot phases
// Max wait for the DAC buffer to fill
`define HW_BUF_LOAD_WAIT 40
// Max wait for the SPI subsystem to come up
`define HW_SPI_START_WAIT 40

// Phase counter width
`define HW_TIMER_W 32

// Board population and field widths
`define HW_NUM_BOARDS 8
`define HW_BOARD_W 3
// Status code field of the status word
`define HW_CODE_W 25
// Sequencer state field of the status word
`define HW_STATE_W 4

`endif

/* design/hw_fault_pkg.sv */
`include "hw_mgr_cfg.svh"

package hw_fault_pkg;

  // Status codes, numbering follows the software side
  // Gaps at 15-18 and 25-26 are retired codes
  typedef enum logic [`HW_CODE_W-1:0] {
    OK                   = `HW_CODE_W'd1,
    PS_SHUTDOWN          = `HW_CODE_W'd2,  // sys_en dropped while running
    TRIG_LOCKOUT_OOB     = `HW_CODE_W'd3,  // Config checks start here
    CAL_OFFSET_OOB       = `HW_CODE_W'd4,
    DAC_DIVIDER_OOB      = `HW_CODE_W'd5,
    INTEG_THRESH_AVG_OOB = `HW_CODE_W'd6,
    INTEG_WINDOW_OOB     = `HW_CODE_W'd7,
    INTEG_EN_OOB         = `HW_CODE_W'd8,
    SYS_EN_OOB           = `HW_CODE_W'd9,
    LOCK_VIOL            = `HW_CODE_W'd10,
    SHUTDOWN_SENSE       = `HW_CODE_W'd11, // Board from sense_num
    EXT_SHUTDOWN         = `HW_CODE_W'd12,
    DAC_OVER_THRESH      = `HW_CODE_W'd13, // Per-board codes start here
    ADC_OVER_THRESH      = `HW_CODE_W'd14,
    DAC_BUF_UNDERFLOW    = `HW_CODE_W'd19,
    DAC_BUF_OVERFLOW     = `HW_CODE_W'd20,
    ADC_BUF_UNDERFLOW    = `HW_CODE_W'd21,
    ADC_BUF_OVERFLOW     = `HW_CODE_W'd22,
    PREMAT_DAC_TRIG      = `HW_CODE_W'd23,
    PREMAT_ADC_TRIG      = `HW_CODE_W'd24,
    BUF_FILL_TIMEOUT     = `HW_CODE_W'd27,
    SPI_START_TIMEOUT    = `HW_CODE_W'd28
  } status_code_e;

  // Config out-of-bounds flags, highest priority first
  typedef struct packed {
    logic trig_lockout;
    logic cal_offset;
    logic dac_divider;
    logic integ_thresh_avg;
    logic integ_window;
    logic integ_en;
    logic sys_en;
  } cfg_oob_t;

  // System-wide fault sources
  typedef struct packed {
    logic                   lock_viol;      // Write to locked config
    logic                   shutdown_sense;
    logic [`HW_BOARD_W-1:0] sense_num;      // Board that tripped the sense
    logic                   ext_shutdown;
  } sys_fault_t;

  // Per-board fault vectors, highest priority first
  typedef struct packed {
    logic [`HW_NUM_BOARDS-1:0] dac_over_thresh;
    logic [`HW_NUM_BOARDS-1:0] adc_over_thresh;
    logic [`HW_NUM_BOARDS-1:0] dac_buf_underflow;
    logic [`HW_NUM_BOARDS-1:0] dac_buf_overflow;
    logic [`HW_NUM_BOARDS-1:0] adc_buf_underflow;
    logic [`HW_NUM_BOARDS-1:0] adc_buf_overflow;
    logic [`HW_NUM_BOARDS-1:0] premat_dac_trig;
    logic [`HW_NUM_BOARDS-1:0] premat_adc_trig;
  } board_fault_t;

  // Encoded result of a priority check
  typedef struct packed {
    logic                   valid; // Some source is active
    status_code_e           code;
    logic [`HW_BOARD_W-1:0] board;
  } fault_report_t;

endpackage

/* design/hw_state_pkg.sv */
`include "hw_mgr_cfg.svh"

package hw_state_pkg;

  // Sequencer states, numbering is visible in the status word
  typedef enum logic [`HW_STATE_W-1:0] {
    IDLE         = `HW_STATE_W'd1, // Powered down, waiting for sys_en
    RELEASE_SD_F = `HW_STATE_W'd2, // Shutdown force released
    PULSE_SD_RST = `HW_STATE_W'd3, // Shutdown reset held low
    SD_RST_DELAY = `HW_STATE_W'd4, // Settling after the pulse
    START_DMA    = `HW_STATE_W'd5, // Waiting on DAC buffer fill
    START_SPI    = `HW_STATE_W'd6, // Waiting on SPI start
    RUNNING      = `HW_STATE_W'd7,
    HALTED       = `HW_STATE_W'd8  // Stopped on fault or bad config
  } hw_state_e;

  // Control outputs to the rest of the system
  typedef struct packed {
    logic sys_rst;          // System reset
    logic unlock_cfg;       // Config registers writable
    logic dma_en;
    logic spi_en;
    logic trig_en;
    logic n_shutdown_force; // Active low
    logic n_shutdown_rst;   // Active low
  } hw_ctrl_t;

  // Status word as seen by software
  // Board in the top bits, state in the bottom bits
  typedef struct packed {
    logic [`HW_BOARD_W-1:0]     board;
    hw_fault_pkg::status_code_e code;
    hw_state_e                  state;
  } status_word_t;

endpackage

/* design/fault_encoder.sv */
`timescale 1ns/1ps

`include "hw_mgr_cfg.svh"

module fault_encoder (
  input  logic                        sys_en,
  input  hw_fault_pkg::cfg_oob_t      cfg_oob,
  input  hw_fault_pkg::sys_fault_t    sys_fault,
  input  hw_fault_pkg::board_fault_t  board_fault,
  output hw_fault_pkg::fault_report_t cfg_report, // Pre-boot config check
  output hw_fault_pkg::fault_report_t run_report  // Run-time fault check
);

  // Lowest set bit of a per-board vector, 0 when empty
  function automatic logic [`HW_BOARD_W-1:0] lowest_board(
    input logic [`HW_NUM_BOARDS-1:0] vec
  );
    logic [`HW_BOARD_W-1:0] idx;
    idx = '0;
    // Scan downward so the lowest hit wins
    for (int i = `HW_NUM_BOARDS - 1; i >= 0; i--) begin
      if (vec[i]) idx = i[`HW_BOARD_W-1:0];
    end
    return idx;
  endfunction

  // Config flags carry no board number
  always_comb begin
    cfg_report.valid = 1'b1;
    cfg_report.board = '0;
    if (cfg_oob.trig_lockout)          cfg_report.code = hw_fault_pkg::TRIG_LOCKOUT_OOB;
    else if (cfg_oob.cal_offset)       cfg_report.code = hw_fault_pkg::CAL_OFFSET_OOB;
    else if (cfg_oob.dac_divider)      cfg_report.code = hw_fault_pkg::DAC_DIVIDER_OOB;
    else if (cfg_oob.integ_thresh_avg) cfg_report.code = hw_fault_pkg::INTEG_THRESH_AVG_OOB;
    else if (cfg_oob.integ_window)     cfg_report.code = hw_fault_pkg::INTEG_WINDOW_OOB;
    else if (cfg_oob.integ_en)         cfg_report.code = hw_fault_pkg::INTEG_EN_OOB;
    else if (cfg_oob.sys_en)           cfg_report.code = hw_fault_pkg::SYS_EN_OOB;
    else begin
      cfg_report.valid = 1'b0; // All config in range
      cfg_report.code  = hw_fault_pkg::OK;
    end
  end

  // Run-time sources in fixed priority
  always_comb begin
    run_report.valid = 1'b1;
    run_report.board = '0;
    if (!sys_en) begin
      run_report.code = hw_fault_pkg::PS_SHUTDOWN; // Software pulled the enable
    end else if (sys_fault.lock_viol) begin
      run_report.code = hw_fault_pkg::LOCK_VIOL;
    end else if (sys_fault.shutdown_sense) begin
      run_report.code  = hw_fault_pkg::SHUTDOWN_SENSE;
      run_report.board = sys_fault.sense_num; // Sense core names the board
    end else if (sys_fault.ext_shutdown) begin
      run_report.code = hw_fault_pkg::EXT_SHUTDOWN;
    end else if (|board_fault.dac_over_thresh) begin
      run_report.code  = hw_fault_pkg::DAC_OVER_THRESH;
      run_report.board = lowest_board(board_fault.dac_over_thresh);
    end else if (|board_fault.adc_over_thresh) begin
      run_report.code  = hw_fault_pkg::ADC_OVER_THRESH;
      run_report.board = lowest_board(board_fault.adc_over_thresh);
    end else if (|board_fault.dac_buf_underflow) begin
      run_report.code  = hw_fault_pkg::DAC_BUF_UNDERFLOW;
      run_report.board = lowest_board(board_fault.dac_buf_underflow);
    end else if (|board_fault.dac_buf_overflow) begin
      run_report.code  = hw_fault_pkg::DAC_BUF_OVERFLOW;
      run_report.board = lowest_board(board_fault.dac_buf_overflow);
    end else if (|board_fault.adc_buf_underflow) begin
      run_report.code  = hw_fault_pkg::ADC_BUF_UNDERFLOW;
      run_report.board = lowest_board(board_fault.adc_buf_underflow);
    end else if (|board_fault.adc_buf_overflow) begin
      run_report.code  = hw_fault_pkg::ADC_BUF_OVERFLOW;
      run_report.board = lowest_board(board_fault.adc_buf_overflow);
    end else if (|board_fault.premat_dac_trig) begin
      // Trigger arrived before the DAC was ready
      run_report.code  = hw_fault_pkg::PREMAT_DAC_TRIG;
      run_report.board = lowest_board(board_fault.premat_dac_trig);
    end else if (|board_fault.premat_adc_trig) begin
      run_report.code  = hw_fault_pkg::PREMAT_ADC_TRIG;
      run_report.board = lowest_board(board_fault.premat_adc_trig);
    end else begin
      run_report.valid = 1'b0; // Nothing wrong
      run_report.code  = hw_fault_pkg::OK;
    end
  end

endmodule

/* design/phase_timer.sv */
`timescale 1ns/1ps

`include "hw_mgr_cfg.svh"

module phase_timer (
  input  logic                   clk,
  input  logic                   rst,
  input  hw_state_pkg::hw_state_e phase,   // Current sequencer state
  input  logic                   restart, // Phase change, clear the count
  output logic                   expired  // Delay of this phase used up
);

  logic [`HW_TIMER_W-1:0] count;
  logic [`HW_TIMER_W-1:0] limit;
  logic                   timed;  // Phase has a delay at all

  // Delay per phase
  always_comb begin
    timed = 1'b1;
    case (phase)
      hw_state_pkg::RELEASE_SD_F: limit = `HW_SD_FORCE_DELAY;
      hw_state_pkg::PULSE_SD_RST: limit = `HW_SD_RST_PULSE;
      hw_state_pkg::SD_RST_DELAY: limit = `HW_SD_RST_DELAY;
      hw_state_pkg::START_DMA:    limit = `HW_BUF_LOAD_WAIT;  // Fill timeout
      hw_state_pkg::START_SPI:    limit = `HW_SPI_START_WAIT; // SPI timeout
      default: begin
        // IDLE, RUNNING and HALTED wait on events only
        timed = 1'b0;
        limit = '0;
      end
    endcase
  end

  // Count from phase entry, park at the limit
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      count <= '0;
    end else if (restart) begin
      count <= '0;
    end else if (count < limit) begin
      count <= count + 1'b1;
    end
  end

  // High from the cycle the count reaches the limit
  assign expired = timed && (count >= limit);

endmodule

/* design/hw_sequencer.sv */
`timescale 1ns/1ps

`include "hw_mgr_cfg.svh"

module hw_sequencer (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        sys_en,
  input  logic                        dac_buf_loaded, // DAC buffer preloaded by DMA
  input  logic                        spi_running,    // SPI subsystem up
  input  hw_fault_pkg::fault_report_t cfg_report,
  input  hw_fault_pkg::fault_report_t run_report,
  input  logic                        expired,        // Phase delay elapsed
  output hw_state_pkg::hw_state_e     phase,
  output logic                        restart,        // Clears the phase timer
  output hw_state_pkg::hw_ctrl_t      ctrl,
  output hw_state_pkg::status_word_t  status,
  output logic                        ps_interrupt
);

  // Powered down, config open, shutdown forced
  localparam hw_state_pkg::hw_ctrl_t CTRL_RST = '{
    sys_rst:          1'b1,
    unlock_cfg:       1'b1,
    dma_en:           1'b0,
    spi_en:           1'b0,
    trig_en:          1'b0,
    n_shutdown_force: 1'b0,
    n_shutdown_rst:   1'b1
  };

  hw_state_pkg::hw_state_e    state;
  hw_state_pkg::hw_state_e    state_n;
  hw_state_pkg::hw_ctrl_t     ctrl_n;
  hw_fault_pkg::status_code_e code_q;
  hw_fault_pkg::status_code_e code_n;
  logic [`HW_BOARD_W-1:0]     board_q;
  logic [`HW_BOARD_W-1:0]     board_n;
  logic                       irq_n;

  // Halt drops all enables and forces shutdown again
  // Config stays locked until software clears sys_en
  function automatic hw_state_pkg::hw_ctrl_t halt_ctrl(input hw_state_pkg::hw_ctrl_t c);
    hw_state_pkg::hw_ctrl_t h;
    h                  = c;
    h.sys_rst          = 1'b1;
    h.n_shutdown_force = 1'b0;
    h.dma_en           = 1'b0;
    h.spi_en           = 1'b0;
    h.trig_en          = 1'b0;
    return h;
  endfunction

  always_comb begin
    state_n = state;
    ctrl_n  = ctrl;
    code_n  = code_q;
    board_n = board_q;
    irq_n   = 1'b0; // Interrupt is a single-cycle pulse
    case (state)
      hw_state_pkg::IDLE: begin
        if (sys_en) begin
          if (cfg_report.valid) begin
            // Bad config, refuse to boot
            state_n = hw_state_pkg::HALTED;
            code_n  = cfg_report.code;
            board_n = cfg_report.board;
            irq_n   = 1'b1;
          end else begin
            state_n                 = hw_state_pkg::RELEASE_SD_F;
            ctrl_n.sys_rst          = 1'b0;
            ctrl_n.unlock_cfg       = 1'b0; // Lock config for the run
            ctrl_n.n_shutdown_force = 1'b1;
          end
        end
      end
      hw_state_pkg::RELEASE_SD_F: begin
        if (expired) begin
          state_n               = hw_state_pkg::PULSE_SD_RST;
          ctrl_n.n_shutdown_rst = 1'b0; // Pulse start
        end
      end
      hw_state_pkg::PULSE_SD_RST: begin
        if (expired) begin
          state_n               = hw_state_pkg::SD_RST_DELAY;
          ctrl_n.n_shutdown_rst = 1'b1; // Pulse end
        end
      end
      hw_state_pkg::SD_RST_DELAY: begin
        if (expired) begin
          state_n       = hw_state_pkg::START_DMA;
          ctrl_n.dma_en = 1'b1;
        end
      end
      hw_state_pkg::START_DMA: begin
        // Buffer ready wins over a timeout in the same cycle
        if (dac_buf_loaded) begin
          state_n       = hw_state_pkg::START_SPI;
          ctrl_n.spi_en = 1'b1;
        end else if (expired) begin
          state_n = hw_state_pkg::HALTED;
          ctrl_n  = halt_ctrl(ctrl);
          code_n  = hw_fault_pkg::BUF_FILL_TIMEOUT;
          irq_n   = 1'b1;
        end
      end
      hw_state_pkg::START_SPI: begin
        if (spi_running) begin
          state_n        = hw_state_pkg::RUNNING;
          ctrl_n.trig_en = 1'b1;
          irq_n          = 1'b1; // Tell software we are up
        end else if (expired) begin
          state_n = hw_state_pkg::HALTED;
          ctrl_n  = halt_ctrl(ctrl);
          code_n  = hw_fault_pkg::SPI_START_TIMEOUT;
          irq_n   = 1'b1;
        end
      end
      hw_state_pkg::RUNNING: begin
        if (run_report.valid) begin
          state_n = hw_state_pkg::HALTED;
          ctrl_n  = halt_ctrl(ctrl);
          code_n  = run_report.code;  // Encoder already picked the winner
          board_n = run_report.board;
          irq_n   = 1'b1;
        end
      end
      hw_state_pkg::HALTED: begin
        // Hold the fault until software acknowledges with sys_en low
        if (!sys_en) begin
          state_n           = hw_state_pkg::IDLE;
          code_n            = hw_fault_pkg::OK;
          board_n           = '0;
          ctrl_n.unlock_cfg = 1'b1;
        end
      end
      default: state_n = hw_state_pkg::IDLE; // Recover from illegal encodings
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state        <= hw_state_pkg::IDLE;
      ctrl         <= CTRL_RST;
      code_q       <= hw_fault_pkg::OK;
      board_q      <= '0;
      ps_interrupt <= 1'b0;
    end else begin
      state        <= state_n;
      ctrl         <= ctrl_n;
      code_q       <= code_n;
      board_q      <= board_n;
      ps_interrupt <= irq_n;
    end
  end

  assign phase   = state;
  assign restart = (state_n != state); // Timer starts at zero in each new phase

  assign status.board = board_q;
  assign status.code  = code_q;
  assign status.state = state;

endmodule

/* design/hw_manager.sv */
`timescale 1ns/1ps

module hw_manager (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       sys_en,         // Software power-on request
  input  logic                       dac_buf_loaded,
  input  logic                       spi_running,
  input  hw_fault_pkg::cfg_oob_t     cfg_oob,
  input  hw_fault_pkg::sys_fault_t   sys_fault,
  input  hw_fault_pkg::board_fault_t board_fault,
  output hw_state_pkg::hw_ctrl_t     ctrl,
  output hw_state_pkg::status_word_t status,
  output logic                       ps_interrupt
);

  hw_fault_pkg::fault_report_t cfg_report;
  hw_fault_pkg::fault_report_t run_report;
  hw_state_pkg::hw_state_e     phase;
  logic                        restart;
  logic                        expired;

  // Fault priority and board lookup
  fault_encoder i_encoder (
    .sys_en      (sys_en),
    .cfg_oob     (cfg_oob),
    .sys_fault   (sys_fault),
    .board_fault (board_fault),
    .cfg_report  (cfg_report),
    .run_report  (run_report)
  );

  // Per-phase delay and timeout counter
  phase_timer i_timer (
    .clk     (clk),
    .rst     (rst),
    .phase   (phase),
    .restart (restart),
    .expired (expired)
  );

  hw_sequencer i_sequencer (
    .clk            (clk),
    .rst            (rst),
    .sys_en         (sys_en),
    .dac_buf_loaded (dac_buf_loaded),
    .spi_running    (spi_running),
    .cfg_report     (cfg_report),
    .run_report     (run_report),
    .expired        (expired),
    .phase          (phase),
    .restart        (restart),
    .ctrl           (ctrl),
    .status         (status),
    .ps_interrupt   (ps_interrupt)
  );

endmodule

/* testbench/tb_hw_manager.sv */
`timescale 1ns/1ps

`include "hw_mgr_cfg.svh"

module tb_hw_manager;

  logic                       clk;
  logic                       rst;
  logic                       sys_en;
  logic                       dac_buf_loaded;
  logic                       spi_running;
  hw_fault_pkg::cfg_oob_t     cfg_oob;
  hw_fault_pkg::sys_fault_t   sys_fault;
  hw_fault_pkg::board_fault_t board_fault;
  hw_state_pkg::hw_ctrl_t     ctrl;
  hw_state_pkg::status_word_t status;
  logic                       ps_interrupt;

  integer seed = 66684; // Fault injection gap
  int     fd;
  int     n_tests;
  string  line;

  // Fields of the current test vector
  logic        run_en;    // sys_en while faults are applied
  logic [6:0]  t_cfg;
  int          buf_dly;   // Negative means the buffer never loads
  int          spi_dly;
  logic        t_lock;
  logic        t_sense;
  logic [2:0]  t_snum;
  logic        t_ext;
  logic [63:0] t_board;
  int          exp_code;
  int          exp_board;
  int          exp_state;

  hw_manager i_dut (
    .clk            (clk),
    .rst            (rst),
    .sys_en         (sys_en),
    .dac_buf_loaded (dac_buf_loaded),
    .spi_running    (spi_running),
    .cfg_oob        (cfg_oob),
    .sys_fault      (sys_fault),
    .board_fault    (board_fault),
    .ctrl           (ctrl),
    .status         (status),
    .ps_interrupt   (ps_interrupt)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk; // 100 ns period
  end

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("** Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, actual, expected);
      $display("*** FAILED ***");
      $fatal(1, "Check failed");
    end
  endtask

  // Samples on falling edges and returns the cycle count to the target state
  // Outputs must hold the given ctrl value and no interrupt until then
  task automatic wait_for_state(input hw_state_pkg::hw_state_e target, input int limit,
                                input logic [6:0] hold, output int cycles);
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (status.state !== target) begin
        check_value(64'(ctrl), 64'(hold), "ctrl inside phase");
        check_value(64'(ps_interrupt), 64'(0), "interrupt inside phase");
      end
    end while (status.state !== target && cycles < limit);
    if (status.state !== target) begin
      $display("Timed out after %0d cycles waiting for sequencer state %0d", limit, target);
      $display("*** FAILED ***");
      $fatal(1, "Timeout");
    end
  endtask

  // Ctrl bits from the top are sys_rst unlock_cfg dma_en spi_en trig_en
  // n_shutdown_force n_shutdown_rst
  task automatic boot_sequence(output logic up);
    int n;
    up = 1'b0;
    wait_for_state(hw_state_pkg::RELEASE_SD_F, 5, 7'b1100001, n);
    check_value(64'(n), 64'(1), "cycles to leave IDLE");
    check_value(64'(ctrl), 64'(7'b0000011), "ctrl after force release");
    wait_for_state(hw_state_pkg::PULSE_SD_RST, `HW_SD_FORCE_DELAY + 10, 7'b0000011, n);
    check_value(64'(n), 64'(`HW_SD_FORCE_DELAY + 1), "force release to reset pulse");
    check_value(64'(ctrl), 64'(7'b0000010), "ctrl during reset pulse");
    wait_for_state(hw_state_pkg::SD_RST_DELAY, `HW_SD_RST_PULSE + 10, 7'b0000010, n);
    check_value(64'(n), 64'(`HW_SD_RST_PULSE + 1), "n_shutdown_rst low width");
    check_value(64'(ctrl), 64'(7'b0000011), "ctrl after reset pulse");
    wait_for_state(hw_state_pkg::START_DMA, `HW_SD_RST_DELAY + 10, 7'b0000011, n);
    check_value(64'(n), 64'(`HW_SD_RST_DELAY + 1), "reset pulse end to dma_en");
    check_value(64'(ctrl), 64'(7'b0010011), "ctrl after DMA start");
    if (buf_dly < 0) begin
      // Buffer never fills
      wait_for_state(hw_state_pkg::HALTED, `HW_BUF_LOAD_WAIT + 10, 7'b0010011, n);
      check_value(64'(n), 64'(`HW_BUF_LOAD_WAIT + 1), "buffer fill timeout length");
      check_value(64'(ctrl), 64'(7'b1000001), "ctrl after fill timeout");
      check_value(64'(ps_interrupt), 64'(1), "interrupt on fill timeout");
    end else begin
      repeat (buf_dly) @(negedge clk);
      dac_buf_loaded = 1'b1;
      wait_for_state(hw_state_pkg::START_SPI, 5, 7'b0010011, n);
      check_value(64'(n), 64'(1), "dac_buf_loaded to spi_en");
      check_value(64'(ctrl), 64'(7'b0011011), "ctrl after SPI start");
      if (spi_dly < 0) begin
        wait_for_state(hw_state_pkg::HALTED, `HW_SPI_START_WAIT + 10, 7'b0011011, n);
        check_value(64'(n), 64'(`HW_SPI_START_WAIT + 1), "SPI start timeout length");
        check_value(64'(ctrl), 64'(7'b1000001), "ctrl after SPI timeout");
        check_value(64'(ps_interrupt), 64'(1), "interrupt on SPI timeout");
      end else begin
        repeat (spi_dly) @(negedge clk);
        spi_running = 1'b1;
        wait_for_state(hw_state_pkg::RUNNING, 5, 7'b0011011, n);
        check_value(64'(n), 64'(1), "spi_running to trig_en");
        check_value(64'(ctrl), 64'(7'b0011111), "ctrl when running");
        check_value(64'(ps_interrupt), 64'(1), "interrupt on entering RUNNING");
        check_value(64'(status.code), 64'(1), "code when running");
        up = 1'b1;
      end
    end
  endtask

  task automatic inject_fault();
    int n;
    int gap;
    @(negedge clk);
    check_value(64'(ps_interrupt), 64'(0), "RUNNING interrupt width");
    gap = 1 + ({$random(seed)} % 10); // 1 to 10 cycles into RUNNING
    repeat (gap - 1) @(negedge clk);
    check_value(64'(status.state), 64'(7), "state before fault");
    sys_en      = run_en;
    sys_fault   = {t_lock, t_sense, t_snum, t_ext};
    board_fault = t_board;
    wait_for_state(hw_state_pkg::HALTED, 5, 7'b0011111, n);
    check_value(64'(n), 64'(1), "fault to halt latency");
    check_value(64'(ctrl), 64'(7'b1000001), "ctrl after run-time halt"); // Config stays locked
    check_value(64'(ps_interrupt), 64'(1), "interrupt on run-time halt");
  endtask

  task automatic recover_to_idle();
    int         n;
    logic [6:0] halted_ctrl; // A config halt leaves the reset outputs alone
    halted_ctrl    = (t_cfg != 7'd0) ? 7'b1100001 : 7'b1000001;
    sys_en         = 1'b0; // Software acknowledge
    dac_buf_loaded = 1'b0;
    spi_running    = 1'b0;
    cfg_oob        = '0;
    sys_fault      = '0;
    board_fault    = '0;
    wait_for_state(hw_state_pkg::IDLE, 5, halted_ctrl, n);
    check_value(64'(n), 64'(1), "HALTED to IDLE latency");
    check_value(64'(ps_interrupt), 64'(0), "halt interrupt width");
    check_value(64'(ctrl), 64'(7'b1100001), "ctrl back in IDLE");
    check_value(64'(status), 64'({3'd0, 25'd1, 4'd1}), "status back in IDLE");
  endtask

  task automatic run_vector();
    int   fields;
    int   n;
    logic up;
    fields = $sscanf(line, "%d %b %d %d %d %d %d %d %h %d %d %d", run_en, t_cfg,
                     buf_dly, spi_dly, t_lock, t_sense, t_snum, t_ext, t_board,
                     exp_code, exp_board, exp_state);
    if (fields != 12) begin
      $display("Malformed test vector: %s", line);
      $display("*** FAILED ***");
      $fatal(1, "Bad test file");
    end
    cfg_oob = t_cfg;
    sys_en  = 1'b1;
    if (t_cfg != 7'd0) begin
      // Config check refuses the boot and outputs keep reset values
      wait_for_state(hw_state_pkg::HALTED, 5, 7'b1100001, n);
      check_value(64'(n), 64'(1), "config halt latency");
      check_value(64'(ctrl), 64'(7'b1100001), "ctrl after config halt");
      check_value(64'(ps_interrupt), 64'(1), "interrupt on config halt");
    end else begin
      boot_sequence(up);
      if (up) inject_fault();
    end
    check_value(64'(status.code), 64'(exp_code), "status code");
    check_value(64'(status.board), 64'(exp_board), "status board");
    check_value(64'(status.state), 64'(exp_state), "status state");
    recover_to_idle();
  endtask

  initial begin
    rst            = 1'b1;
    sys_en         = 1'b0;
    dac_buf_loaded = 1'b0;
    spi_running    = 1'b0;
    cfg_oob        = '0;
    sys_fault      = '0;
    board_fault    = '0;
    n_tests        = 0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    check_value(64'(ctrl), 64'(7'b1100001), "ctrl after reset");
    check_value(64'(ps_interrupt), 64'(0), "interrupt after reset");
    check_value(64'(status), 64'({3'd0, 25'd1, 4'd1}), "status after reset"); // Board 0, OK, IDLE

    fd = $fopen("testbench/hw_manager_tests.txt", "r");
    if (fd == 0) begin
      $display("Could not open the test vector file");
      $display("*** FAILED ***");
      $fatal(1, "No test file");
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 1 && line[0] != "#") begin // Skip comments and blank lines
        run_vector();
        n_tests++;
      end
    end
    $fclose(fd);

    if (n_tests == 0) begin
      $display("No test vectors found in the test file");
      $display("*** FAILED ***");
      $fatal(1, "Empty test file");
    end else begin
      $display("Ran %0d test vectors", n_tests);
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

/* testbench/hw_manager_tests.txt */
# en cfg_oob buf_dly spi_dly lock sense snum ext board_fault(hex) code board state
# en is sys_en while faults are applied, delays in cycles, -1 means never
0 0000000 3 2 0 0 0 0 0000000000000000 2 0 8
1 0110100 0 0 0 0 0 0 0000000000000000 4 0 8
1 0000011 0 0 0 0 0 0 0000000000000000 8 0 8
1 0000001 0 0 0 0 0 0 0000000000000000 9 0 8
1 1111111 0 0 0 0 0 0 0000000000000000 3 0 8
1 0001000 0 0 0 0 0 0 0000000000000000 6 0 8
1 0000000 -1 0 0 0 0 0 0000000000000000 27 0 8
1 0000000 2 -1 0 0 0 0 0000000000000000 28 0 8
1 0000000 39 5 1 1 5 1 FF00000000000000 10 0 8
1 0000000 0 0 0 1 5 1 FF00000000000000 11 5 8
1 0000000 1 1 0 0 2 1 00FF000000000000 12 0 8
1 0000000 4 3 0 0 0 0 2801000000000000 13 3 8
1 0000000 0 0 0 0 0 0 0090000000000080 14 4 8
1 0000000 0 0 0 0 0 0 0000800000000001 19 7 8
1 0000000 0 0 0 0 0 0 0000000600000000 20 1 8
1 0000000 0 0 0 0 0 0 0000000040000000 21 6 8
1 0000000 0 0 0 0 0 0 00000000000C0001 22 2 8
1 0000000 0 0 0 0 0 0 0000000000001000 23 4 8
1 0000000 0 0 0 0 0 0 00000000000000FF 24 0 8
0 0000000 5 0 1 0 0 1 0000000000000001 2 0 8
1 0000000 0 39 0 0 0 0 8000000000000000 13 7 8

/* all.f */
+incdir+design
design/hw_fault_pkg.sv
design/hw_state_pkg.sv
design/fault_encoder.sv
design/phase_timer.sv
design/hw_sequencer.sv
design/hw_manager.sv
testbench/tb_hw_manager.sv

/* Makefile */
SIM = obj_dir/Vtb_hw_manager

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --timescale 1ns/1ps -f all.f --top-module tb_hw_manager

run: build
	./$(SIM) > sim.log 2>&1 || true
	cat sim.log
	grep -qF '*** PASSED ***' sim.log

lint:
	verilator --lint-only -Wall --timescale 1ns/1ps +incdir+design \
	  design/hw_fault_pkg.sv design/hw_state_pkg.sv design/fault_encoder.sv \
	  design/phase_timer.sv design/hw_sequencer.sv design/hw_manager.sv \
	  --top-module hw_manager

clean:
	rm -rf obj_dir sim.log
